// File: hw/axi_pkg.sv
package axi_pkg;

	// bus widths
	localparam int ADDR_W = 64;
	localparam int DATA_W = 256;
	localparam int STRB_W = DATA_W / 8;
	localparam int ID_W = 6;
	localparam int LEN_W = 8;
	localparam int RESP_W = 2;

	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

	// write address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [LEN_W-1:0] len;
	} aw_req_t;

	// write data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic last;
	} w_beat_t;

	// write response channel
	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [RESP_W-1:0] resp;
	} b_resp_t;

	// read address channel
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0] id;
		logic [LEN_W-1:0] len;
	} ar_req_t;

	// read data channel
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [ID_W-1:0] id;
		logic [RESP_W-1:0] resp;
		logic last;
	} r_beat_t;

endpackage

// File: hw/mem_pkg.sv
package mem_pkg;

	localparam int BEATS_PER_LINE = 2;
	localparam int BEAT_BYTES = axi_pkg::STRB_W;

	// bit 5 picks the beat and bits 6 and up the line
	localparam int BEAT_BIT = 5;
	localparam int LINE_LSB = 6;
	localparam int LINE_IDX_MAX_W = 16;

	typedef logic beat_sel_t;

	typedef struct packed {
		logic en;
		logic [LINE_IDX_MAX_W-1:0] line;
		beat_sel_t beat;
		logic [axi_pkg::DATA_W-1:0] data;
		logic [axi_pkg::STRB_W-1:0] strb;
	} store_wr_t;

	typedef struct packed {
		logic en;
		logic [LINE_IDX_MAX_W-1:0] line;
		beat_sel_t beat;
	} store_rd_t;

	function automatic logic [LINE_IDX_MAX_W-1:0] line_of(input logic [axi_pkg::ADDR_W-1:0] addr);
		return addr[LINE_LSB +: LINE_IDX_MAX_W];
	endfunction

	function automatic beat_sel_t beat_of(input logic [axi_pkg::ADDR_W-1:0] addr);
		return addr[BEAT_BIT];
	endfunction

endpackage

// File: hw/line_store.sv
`timescale 1ns/100ps

module line_store
	import axi_pkg::*, mem_pkg::*;
#(
	parameter int LINE_W = 10
) (
	input logic clk,
	input store_wr_t store_wr,
	input store_rd_t store_rd,
	output logic [DATA_W-1:0] rd_data
);

	localparam int LINES = 2 ** LINE_W;

	logic [DATA_W-1:0] mem [LINES][BEATS_PER_LINE];

	logic [LINE_W-1:0] wr_line;
	logic [LINE_W-1:0] rd_line;

	// only the low LINE_W bits of the line index are used
	assign wr_line = store_wr.line[LINE_W-1:0];
	assign rd_line = store_rd.line[LINE_W-1:0];

	// unstrobed bytes keep their old contents
	always_ff @(posedge clk) begin
		if (store_wr.en) begin
			for (int i = 0; i < BEAT_BYTES; i++) begin
				if (store_wr.strb[i]) begin
					mem[wr_line][store_wr.beat][8*i +: 8] <= store_wr.data[8*i +: 8];
				end
			end
		end
	end

	// read data one cycle after the request
	always_ff @(posedge clk) begin
		if (store_rd.en) begin
			rd_data <= mem[rd_line][store_rd.beat];
		end
	end

endmodule

// File: hw/axi_write_channel.sv
`timescale 1ns/100ps

module axi_write_channel
	import axi_pkg::*, mem_pkg::*;
#(
	parameter int LINE_W = 10,
	parameter int B_QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	input aw_req_t aw,
	output logic aw_ready,
	input logic w_valid,
	input w_beat_t w,
	output logic w_ready,
	output logic b_valid,
	output b_resp_t b,
	input logic b_ready,
	output store_wr_t store_wr
);

	localparam int PTR_W = (B_QUEUE_DEPTH > 1) ? $clog2(B_QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(B_QUEUE_DEPTH + 1);

	// burst context
	logic wr_open;
	logic [ID_W-1:0] id_q;
	logic [LINE_W-1:0] line_q;
	beat_sel_t beat_q;

	// response queue
	logic [ID_W-1:0] q_mem [B_QUEUE_DEPTH];
	logic [PTR_W-1:0] q_wr_ptr;
	logic [PTR_W-1:0] q_rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic q_full;
	logic q_push;

	logic aw_fire;
	logic w_fire;
	logic b_fire;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(B_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign q_full = (q_count == CNT_W'(B_QUEUE_DEPTH));
	// one burst at a time, and only with room for its response
	assign aw_ready = !wr_open && !q_full;
	assign w_ready = wr_open;
	assign b_valid = (q_count != '0);

	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;
	assign b_fire = b_valid && b_ready;
	assign q_push = w_fire && w.last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_open <= 1'b0;
		end else if (aw_fire) begin
			wr_open <= 1'b1;
		end else if (q_push) begin
			wr_open <= 1'b0;
		end
	end

	// beat index wraps inside the line
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			id_q <= aw.id;
			line_q <= LINE_W'(line_of(aw.addr));
			beat_q <= beat_of(aw.addr);
		end else if (w_fire) begin
			beat_q <= beat_q + 1'b1;
		end
	end

	always_comb begin
		store_wr.en = w_fire;
		store_wr.line = LINE_IDX_MAX_W'(line_q);
		store_wr.beat = beat_q;
		store_wr.data = w.data;
		store_wr.strb = w.strb;
	end

	always_ff @(posedge clk) begin
		if (q_push) begin
			q_mem[q_wr_ptr] <= id_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count <= '0;
		end else begin
			if (q_push) begin
				q_wr_ptr <= next_ptr(q_wr_ptr);
			end
			if (b_fire) begin
				q_rd_ptr <= next_ptr(q_rd_ptr);
			end
			if (q_push && !b_fire) begin
				q_count <= q_count + 1'b1;
			end else if (b_fire && !q_push) begin
				q_count <= q_count - 1'b1;
			end
		end
	end

	// oldest response
	assign b.id = q_mem[q_rd_ptr];
	assign b.resp = RESP_OKAY;

endmodule

// File: hw/axi_read_channel.sv
`timescale 1ns/100ps

module axi_read_channel
	import axi_pkg::*, mem_pkg::*;
#(
	parameter int LINE_W = 10
) (
	input logic clk,
	input logic rst_n,
	input logic ar_valid,
	input ar_req_t ar,
	output logic ar_ready,
	output store_rd_t store_rd,
	input logic [DATA_W-1:0] rd_data,
	output logic r_valid,
	output r_beat_t r,
	input logic r_ready
);

	// issue read, wait for store, then hold the beat on R
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_CAP,
		RD_SHOW
	} rd_state_t;

	rd_state_t state;
	logic [ID_W-1:0] id_q;
	logic [LINE_W-1:0] line_q;
	beat_sel_t beat_q;
	logic [LEN_W:0] remain_q;
	r_beat_t r_q;

	logic ar_fire;
	logic r_fire;

	assign ar_ready = (state == RD_IDLE);
	assign r_valid = (state == RD_SHOW);
	assign r = r_q;

	assign ar_fire = ar_valid && ar_ready;
	assign r_fire = r_valid && r_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: if (ar_fire) state <= RD_REQ;
				RD_REQ: state <= RD_CAP;
				RD_CAP: state <= RD_SHOW;
				RD_SHOW: begin
					if (r_fire) begin
						state <= r_q.last ? RD_IDLE : RD_REQ;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// remaining count is len + 1, up to 256 beats
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			id_q <= ar.id;
			line_q <= LINE_W'(line_of(ar.addr));
			beat_q <= beat_of(ar.addr);
			remain_q <= {1'b0, ar.len} + 1'b1;
		end else if (r_fire) begin
			beat_q <= beat_q + 1'b1;
			remain_q <= remain_q - 1'b1;
		end
	end

	always_comb begin
		store_rd.en = (state == RD_REQ);
		store_rd.line = LINE_IDX_MAX_W'(line_q);
		store_rd.beat = beat_q;
	end

	// output register only loads in RD_CAP, so it holds while stalled
	always_ff @(posedge clk) begin
		if (state == RD_CAP) begin
			r_q.data <= rd_data;
			r_q.id <= id_q;
			r_q.resp <= RESP_OKAY;
			r_q.last <= (remain_q == (LEN_W + 1)'(1));
		end
	end

endmodule

// File: hw/axi_mem_top.sv
`timescale 1ns/100ps

module axi_mem_top
	import axi_pkg::*, mem_pkg::*;
#(
	parameter int LINE_W = 10,
	parameter int B_QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic aw_valid,
	input aw_req_t aw,
	output logic aw_ready,
	input logic w_valid,
	input w_beat_t w,
	output logic w_ready,
	output logic b_valid,
	output b_resp_t b,
	input logic b_ready,
	input logic ar_valid,
	input ar_req_t ar,
	output logic ar_ready,
	output logic r_valid,
	output r_beat_t r,
	input logic r_ready
);

	store_wr_t store_wr;
	store_rd_t store_rd;
	logic [DATA_W-1:0] rd_data;

	axi_write_channel #(
		.LINE_W(LINE_W),
		.B_QUEUE_DEPTH(B_QUEUE_DEPTH)
	) u_write_channel (
		.clk(clk),
		.rst_n(rst_n),
		.aw_valid(aw_valid),
		.aw(aw),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w(w),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.b(b),
		.b_ready(b_ready),
		.store_wr(store_wr)
	);

	axi_read_channel #(
		.LINE_W(LINE_W)
	) u_read_channel (
		.clk(clk),
		.rst_n(rst_n),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.store_rd(store_rd),
		.rd_data(rd_data),
		.r_valid(r_valid),
		.r(r),
		.r_ready(r_ready)
	);

	line_store #(
		.LINE_W(LINE_W)
	) u_line_store (
		.clk(clk),
		.store_wr(store_wr),
		.store_rd(store_rd),
		.rd_data(rd_data)
	);

endmodule

// File: verification/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
	parameter int HALF_PERIOD = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// release lines up with the input drive offset
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

// File: verification/tb_axi_mem.sv
`timescale 1ns/100ps

module tb_axi_mem
	import axi_pkg::*;
;

	localparam int LINE_W = 10;
	localparam int B_QUEUE_DEPTH = 4;
	localparam int TIMEOUT = 1000;

	logic clk;
	logic rst_n;
	logic aw_valid;
	aw_req_t aw;
	logic aw_ready;
	logic w_valid;
	w_beat_t w;
	logic w_ready;
	logic b_valid;
	b_resp_t b;
	logic b_ready;
	logic ar_valid;
	ar_req_t ar;
	logic ar_ready;
	logic r_valid;
	r_beat_t r;
	logic r_ready;

	// byte-level reference memory indexed by {line, beat, byte}
	logic [7:0] ref_mem [2 ** (LINE_W + 6)];
	bit ref_ok [2 ** (LINE_W + 6)];
	logic [DATA_W-1:0] wdata [2];
	logic [STRB_W-1:0] wstrb [2];

	// expected R beat and the bytes that are known
	r_beat_t exp_r;
	logic [DATA_W-1:0] exp_mask;
	logic rd_active;

	// expected B ids in AW order
	logic [ID_W-1:0] exp_ids [256];
	logic [7:0] exp_wr;
	logic [7:0] exp_rd;
	int w_done;
	int b_done;
	logic wr_open_tb;

	// 0 holds b_ready low, 1 keeps it high, 2 randomizes it
	int b_mode;
	logic r_rand;

	logic rst_q;
	logic r_stall_q;
	r_beat_t r_prev;
	logic b_stall_q;
	b_resp_t b_prev;

	clk_gen u_clk_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	axi_mem_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.aw_valid(aw_valid),
		.aw(aw),
		.aw_ready(aw_ready),
		.w_valid(w_valid),
		.w(w),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.b(b),
		.b_ready(b_ready),
		.ar_valid(ar_valid),
		.ar(ar),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r(r),
		.r_ready(r_ready)
	);

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: the %s handshake never completed", what);
		abort_run();
	endtask

	// beat k of a burst lands on beat (start + k) mod 2 of the line
	function automatic int byte_index(input logic [ADDR_W-1:0] addr, input int k, input int n);
		logic [LINE_W-1:0] line;
		logic beat;
		line = addr[6 +: LINE_W];
		beat = addr[5] ^ k[0];
		return int'({line, beat, n[4:0]});
	endfunction

	function automatic logic [DATA_W-1:0] rand_word();
		logic [DATA_W-1:0] word;
		for (int i = 0; i < DATA_W / 32; i++) begin
			word[32*i +: 32] = $urandom();
		end
		return word;
	endfunction

	task automatic load_expected(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
			input int k, input bit last);
		int idx;
		for (int n = 0; n < STRB_W; n++) begin
			idx = byte_index(addr, k, n);
			exp_r.data[8*n +: 8] = ref_mem[idx];
			exp_mask[8*n +: 8] = ref_ok[idx] ? 8'hff : 8'h00;
		end
		exp_r.id = id;
		exp_r.resp = RESP_OKAY;
		exp_r.last = last;
	endtask

	task automatic write_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
			input int beats);
		int cnt;
		int idx;
		aw.addr = addr;
		aw.id = id;
		aw.len = LEN_W'(beats - 1);
		aw_valid = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!aw_ready) begin
			cnt++;
			if (cnt > TIMEOUT) report_timeout("AW");
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		aw_valid = 1'b0;
		exp_ids[exp_wr] = id;
		exp_wr++;
		wr_open_tb = 1'b1;
		for (int k = 0; k < beats; k++) begin
			w.data = wdata[k];
			w.strb = wstrb[k];
			w.last = (k == beats - 1);
			w_valid = 1'b1;
			cnt = 0;
			@(negedge clk);
			while (!w_ready) begin
				cnt++;
				if (cnt > TIMEOUT) report_timeout("W");
				@(negedge clk);
			end
			@(posedge clk);
			#2;
			// strobe merge into the reference
			for (int n = 0; n < STRB_W; n++) begin
				if (wstrb[k][n]) begin
					idx = byte_index(addr, k, n);
					ref_mem[idx] = wdata[k][8*n +: 8];
					ref_ok[idx] = 1'b1;
				end
			end
		end
		w_valid = 1'b0;
		wr_open_tb = 1'b0;
		w_done++;
	endtask

	task automatic wait_b_drained();
		int cnt;
		cnt = 0;
		@(negedge clk);
		while (b_done != w_done) begin
			cnt++;
			if (cnt > TIMEOUT) report_timeout("B");
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic read_burst(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id,
			input int beats);
		int cnt;
		ar.addr = addr;
		ar.id = id;
		ar.len = LEN_W'(beats - 1);
		ar_valid = 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!ar_ready) begin
			cnt++;
			if (cnt > TIMEOUT) report_timeout("AR");
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		ar_valid = 1'b0;
		for (int k = 0; k < beats; k++) begin
			load_expected(addr, id, k, k == beats - 1);
			rd_active = 1'b1;
			cnt = 0;
			@(negedge clk);
			while (!(r_valid && r_ready)) begin
				cnt++;
				if (cnt > TIMEOUT) report_timeout("R");
				@(negedge clk);
			end
			@(posedge clk);
			#2;
		end
		rd_active = 1'b0;
	endtask

	// ready drivers
	always @(posedge clk) begin
		#2;
		b_ready = (b_mode == 2) ? 1'($urandom_range(0, 1)) : (b_mode == 1);
		r_ready = r_rand ? 1'($urandom_range(0, 1)) : 1'b1;
	end

	// previous-cycle state for the stability checks and B bookkeeping
	always @(posedge clk) begin
		rst_q <= rst_n;
		r_stall_q <= rst_n && r_valid && !r_ready;
		r_prev <= r;
		b_stall_q <= rst_n && b_valid && !b_ready;
		b_prev <= b;
		if (!rst_n) begin
			exp_rd <= '0;
			b_done <= 0;
		end else if (b_valid && b_ready) begin
			exp_rd <= exp_rd + 1'b1;
			b_done <= b_done + 1;
		end
	end

	chk_reset: assert property (@(negedge clk) disable iff (!rst_n)
		!rst_q |-> {aw_ready, ar_ready, w_ready, b_valid, r_valid} == 5'b11000)
		else begin
			$display("ERR %0t {aw_ready,ar_ready,w_ready,b_valid,r_valid} exp=%b act=%b",
				$time, 5'b11000, {aw_ready, ar_ready, w_ready, b_valid, r_valid});
			abort_run();
		end

	chk_r_data: assert property (@(negedge clk) disable iff (!rst_n)
		r_valid && rd_active |-> ((r.data ^ exp_r.data) & exp_mask) == '0)
		else begin
			$display("ERR %0t r.data exp=%h act=%h", $time, exp_r.data & exp_mask,
				r.data & exp_mask);
			abort_run();
		end

	chk_r_id: assert property (@(negedge clk) disable iff (!rst_n)
		r_valid && rd_active |-> r.id == exp_r.id)
		else begin
			$display("ERR %0t r.id exp=%h act=%h", $time, exp_r.id, r.id);
			abort_run();
		end

	chk_r_resp: assert property (@(negedge clk) disable iff (!rst_n)
		r_valid && rd_active |-> r.resp == exp_r.resp)
		else begin
			$display("ERR %0t r.resp exp=%h act=%h", $time, exp_r.resp, r.resp);
			abort_run();
		end

	chk_r_last: assert property (@(negedge clk) disable iff (!rst_n)
		r_valid && rd_active |-> r.last == exp_r.last)
		else begin
			$display("ERR %0t r.last exp=%b act=%b", $time, exp_r.last, r.last);
			abort_run();
		end

	chk_r_spurious: assert property (@(negedge clk) disable iff (!rst_n)
		r_valid |-> rd_active)
		else begin
			$display("r_valid went high with no read burst in progress");
			abort_run();
		end

	chk_r_hold: assert property (@(negedge clk) disable iff (!rst_n)
		r_stall_q |-> r_valid && r == r_prev)
		else begin
			$display("ERR %0t {r_valid,r} exp=%h act=%h", $time, {1'b1, r_prev}, {r_valid, r});
			abort_run();
		end

	// ar_ready stays low from the AR transfer until the last beat transfers
	chk_ar_ready: assert property (@(negedge clk) disable iff (!rst_n)
		ar_ready == !rd_active)
		else begin
			$display("ERR %0t ar_ready exp=%b act=%b", $time, !rd_active, ar_ready);
			abort_run();
		end

	chk_b_id: assert property (@(negedge clk) disable iff (!rst_n)
		b_valid |-> b.id == exp_ids[exp_rd])
		else begin
			$display("ERR %0t b.id exp=%h act=%h", $time, exp_ids[exp_rd], b.id);
			abort_run();
		end

	chk_b_resp: assert property (@(negedge clk) disable iff (!rst_n)
		b_valid |-> b.resp == RESP_OKAY)
		else begin
			$display("ERR %0t b.resp exp=%h act=%h", $time, RESP_OKAY, b.resp);
			abort_run();
		end

	chk_b_spurious: assert property (@(negedge clk) disable iff (!rst_n)
		b_valid |-> exp_rd != exp_wr)
		else begin
			$display("b_valid went high with no write response outstanding");
			abort_run();
		end

	chk_b_hold: assert property (@(negedge clk) disable iff (!rst_n)
		b_stall_q |-> b_valid && b == b_prev)
		else begin
			$display("ERR %0t {b_valid,b} exp=%h act=%h", $time, {1'b1, b_prev}, {b_valid, b});
			abort_run();
		end

	// aw_ready follows the open burst and the count of waiting responses
	chk_aw_full: assert property (@(negedge clk) disable iff (!rst_n)
		!wr_open_tb && (w_done - b_done) == B_QUEUE_DEPTH |-> !aw_ready)
		else begin
			$display("ERR %0t aw_ready exp=0 act=%b", $time, aw_ready);
			abort_run();
		end

	chk_aw_open: assert property (@(negedge clk) disable iff (!rst_n)
		!wr_open_tb && (w_done - b_done) < B_QUEUE_DEPTH |-> aw_ready)
		else begin
			$display("ERR %0t aw_ready exp=1 act=%b", $time, aw_ready);
			abort_run();
		end

	chk_w_ready: assert property (@(negedge clk) disable iff (!rst_n)
		w_ready == wr_open_tb)
		else begin
			$display("ERR %0t w_ready exp=%b act=%b", $time, wr_open_tb, w_ready);
			abort_run();
		end

	initial begin
		int cnt;
		logic [ADDR_W-1:0] addr;
		int beats;

		void'($urandom(12));
		aw_valid = 1'b0;
		aw = '0;
		w_valid = 1'b0;
		w = '0;
		ar_valid = 1'b0;
		ar = '0;
		b_ready = 1'b1;
		r_ready = 1'b1;
		b_mode = 1;
		r_rand = 1'b0;
		rd_active = 1'b0;
		wr_open_tb = 1'b0;
		exp_r = '0;
		exp_mask = '0;
		exp_wr = '0;
		w_done = 0;

		cnt = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			cnt++;
			if (cnt > TIMEOUT) report_timeout("reset release");
		end
		#2;

		// full-strobe round trip from start beat 1
		addr = 64'h1020;
		wdata[0] = rand_word();
		wdata[1] = rand_word();
		wstrb[0] = '1;
		wstrb[1] = '1;
		write_burst(addr, 6'd3, 2);
		wait_b_drained();
		read_burst(addr, 6'd9, 2);

		// partial strobes into the same line
		wdata[0] = rand_word();
		wdata[1] = rand_word();
		wstrb[0] = 32'h0f0f_00ff;
		wstrb[1] = 32'hf000_000f;
		write_burst(64'h1000, 6'd4, 2);
		wait_b_drained();
		read_burst(64'h1000, 6'd10, 2);

		// fill the response queue with b_ready low
		@(negedge clk);
		b_mode = 0;
		@(posedge clk);
		#2;
		for (int i = 0; i < B_QUEUE_DEPTH; i++) begin
			wdata[0] = rand_word();
			wstrb[0] = '1;
			write_burst(64'h2000 + 64'(i) * 64, 6'(20 + i), 1);
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		b_mode = 1;
		wait_b_drained();

		// read back-pressure with a wrapping four-beat burst
		@(negedge clk);
		r_rand = 1'b1;
		@(posedge clk);
		#2;
		read_burst(64'h1000, 6'd30, 2);
		read_burst(64'h1020, 6'd31, 4);

		// random traffic over a few lines
		@(negedge clk);
		b_mode = 2;
		@(posedge clk);
		#2;
		for (int i = 0; i < 40; i++) begin
			addr = {$urandom(), $urandom()};
			addr[6 +: LINE_W] = LINE_W'($urandom_range(0, 15));
			addr[4:0] = '0;
			beats = $urandom_range(1, 2);
			if ($urandom_range(0, 1) == 1) begin
				wdata[0] = rand_word();
				wdata[1] = rand_word();
				wstrb[0] = $urandom();
				wstrb[1] = $urandom();
				write_burst(addr, 6'($urandom()), beats);
				wait_b_drained();
			end else begin
				read_burst(addr, 6'($urandom()), beats);
			end
		end

		@(negedge clk);
		b_mode = 1;
		r_rand = 1'b0;
		repeat (2) @(posedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: build.f
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/line_store.sv
hw/axi_write_channel.sv
hw/axi_read_channel.sv
hw/axi_mem_top.sv
verification/clk_gen.sv
verification/tb_axi_mem.sv

// File: Makefile
# Verilator build and run for the AXI memory testbench

OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_axi_mem -f build.f \
		-Mdir $(OBJ_DIR) -o sim_tb

# the simulator may exit non-zero on failure, the grep decides the status
run: compile
	-./$(OBJ_DIR)/sim_tb > sim.log 2>&1
	cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
